// File: common/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define MIPS_XLEN     32
`define MIPS_REG_AW   5
`define MIPS_NREGS    32
`define MIPS_REG_ZERO 5'd0

// major opcodes
`define OP_SPECIAL 6'b000000
`define OP_ORI     6'b001101
`define OP_ANDI    6'b001100
`define OP_XORI    6'b001110
`define OP_LUI     6'b001111
`define OP_ADDIU   6'b001001
`define OP_SLTI    6'b001010
`define OP_SLTIU   6'b001011

// special function codes
`define FN_OR   6'b100101
`define FN_AND  6'b100100
`define FN_XOR  6'b100110
`define FN_NOR  6'b100111
`define FN_SLL  6'b000000
`define FN_SRL  6'b000010
`define FN_SRA  6'b000011
`define FN_SLLV 6'b000100
`define FN_SRLV 6'b000110
`define FN_SRAV 6'b000111
`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_SLT  6'b101010
`define FN_SLTU 6'b101011

`endif

// File: common/mips_pkg.sv
`include "mips_macros.svh"

package mips_pkg;

  typedef logic [`MIPS_XLEN-1:0]   word_t;
  typedef logic [`MIPS_REG_AW-1:0] reg_addr_t;

  typedef enum logic [3:0] {
    ALU_OR,
    ALU_AND,
    ALU_XOR,
    ALU_NOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_ADDU,
    ALU_SUBU,
    ALU_SLT,
    ALU_SLTU,
    ALU_NOP
  } alu_op_e;

  // result group picked in execute
  typedef enum logic [1:0] {
    SEL_NOP,
    SEL_LOGIC,
    SEL_SHIFT,
    SEL_ARITH
  } alu_sel_e;

  // shifts put the amount in opnd1 and the value in opnd2
  typedef struct packed {
    logic      valid;
    logic      illegal;
    alu_op_e   alu_op;
    alu_sel_e  alu_sel;
    logic      wreg;
    reg_addr_t wd;
    word_t     opnd1;
    word_t     opnd2;
  } ex_req_t;

  typedef struct packed {
    logic      valid;
    logic      illegal;
    logic      wreg;
    reg_addr_t wd;
    word_t     wdata;
  } wb_req_t;

  typedef struct packed {
    logic      wreg;
    reg_addr_t wd;
    word_t     wdata;
  } fwd_t;

endpackage

// File: decode/reg_file.sv
`timescale 1ns/10ps
`include "mips_macros.svh"

module reg_file
  import mips_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  reg_addr_t rs_addr_i,
  input  reg_addr_t rt_addr_i,
  output word_t     rs_data_o,
  output word_t     rt_data_o,
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i
);

  word_t regs [`MIPS_NREGS];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `MIPS_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != `MIPS_REG_ZERO)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // r0 is hardwired
  assign rs_data_o = (rs_addr_i == `MIPS_REG_ZERO) ? '0 : regs[rs_addr_i];
  assign rt_data_o = (rt_addr_i == `MIPS_REG_ZERO) ? '0 : regs[rt_addr_i];

endmodule

// File: decode/inst_decoder.sv
`timescale 1ns/10ps
`include "mips_macros.svh"

module inst_decoder
  import mips_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      inst_valid_i,
  input  word_t     inst_i,
  output reg_addr_t rs_addr_o,
  output reg_addr_t rt_addr_o,
  input  word_t     rs_data_i,
  input  word_t     rt_data_i,
  input  fwd_t      ex_fwd_i,
  input  fwd_t      wb_fwd_i,
  output ex_req_t   ex_req_o
);

  logic [5:0]  op;
  reg_addr_t   rs;
  reg_addr_t   rt;
  reg_addr_t   rd;
  logic [4:0]  shamt;
  logic [5:0]  funct;
  logic [15:0] imm;

  word_t    imm_zext;
  word_t    imm_sext;
  word_t    imm_lui;
  word_t    imm_shamt;
  word_t    imm_fnl;
  alu_op_e  fn_op;
  alu_op_e  alu_op;
  alu_sel_e alu_sel;
  reg_addr_t wd;
  logic     legal;
  logic     rs_re;
  logic     rt_re;
  ex_req_t  ex_req_d;

  assign op    = inst_i[31:26];
  assign rs    = inst_i[25:21];
  assign rt    = inst_i[20:16];
  assign rd    = inst_i[15:11];
  assign shamt = inst_i[10:6];
  assign funct = inst_i[5:0];
  assign imm   = inst_i[15:0];

  assign imm_zext  = {16'h0, imm};
  assign imm_sext  = {{16{imm[15]}}, imm};
  assign imm_lui   = {imm, 16'h0};
  assign imm_shamt = {27'h0, shamt};

  assign rs_addr_o = rs;
  assign rt_addr_o = rt;

  // variable and immediate shifts share one op
  always_comb begin
    case (funct)
      `FN_OR:             fn_op = ALU_OR;
      `FN_AND:            fn_op = ALU_AND;
      `FN_XOR:            fn_op = ALU_XOR;
      `FN_NOR:            fn_op = ALU_NOR;
      `FN_SLL, `FN_SLLV:  fn_op = ALU_SLL;
      `FN_SRL, `FN_SRLV:  fn_op = ALU_SRL;
      `FN_SRA, `FN_SRAV:  fn_op = ALU_SRA;
      `FN_ADDU:           fn_op = ALU_ADDU;
      `FN_SUBU:           fn_op = ALU_SUBU;
      `FN_SLT:            fn_op = ALU_SLT;
      `FN_SLTU:           fn_op = ALU_SLTU;
      default:            fn_op = ALU_NOP;
    endcase
  end

  always_comb begin
    legal   = 1'b0;
    alu_op  = ALU_NOP;
    alu_sel = SEL_NOP;
    rs_re   = 1'b0;
    rt_re   = 1'b0;
    wd      = rd;
    imm_fnl = '0;
    case (op)
      `OP_SPECIAL: begin
        alu_op = fn_op;
        rt_re  = 1'b1;
        case (funct)
          `FN_OR, `FN_AND, `FN_XOR, `FN_NOR: begin
            alu_sel = SEL_LOGIC;
            rs_re   = 1'b1;
            legal   = (shamt == 5'd0);
          end
          `FN_ADDU, `FN_SUBU, `FN_SLT, `FN_SLTU: begin
            alu_sel = SEL_ARITH;
            rs_re   = 1'b1;
            legal   = (shamt == 5'd0);
          end
          `FN_SLLV, `FN_SRLV, `FN_SRAV: begin
            alu_sel = SEL_SHIFT;
            rs_re   = 1'b1;
            legal   = (shamt == 5'd0);
          end
          `FN_SLL, `FN_SRL, `FN_SRA: begin
            alu_sel = SEL_SHIFT;
            imm_fnl = imm_shamt;
            legal   = (rs == `MIPS_REG_ZERO);
          end
          default: ;
        endcase
      end
      `OP_ORI, `OP_ANDI, `OP_XORI: begin
        alu_op  = (op == `OP_ORI) ? ALU_OR : (op == `OP_ANDI) ? ALU_AND : ALU_XOR;
        alu_sel = SEL_LOGIC;
        rs_re   = 1'b1;
        imm_fnl = imm_zext;
        wd      = rt;
        legal   = 1'b1;
      end
      // both operands take the immediate, or of equal values
      `OP_LUI: begin
        alu_op  = ALU_OR;
        alu_sel = SEL_LOGIC;
        imm_fnl = imm_lui;
        wd      = rt;
        legal   = 1'b1;
      end
      `OP_ADDIU, `OP_SLTI, `OP_SLTIU: begin
        alu_op  = (op == `OP_ADDIU) ? ALU_ADDU : (op == `OP_SLTI) ? ALU_SLT : ALU_SLTU;
        alu_sel = SEL_ARITH;
        rs_re   = 1'b1;
        imm_fnl = imm_sext;
        wd      = rt;
        legal   = 1'b1;
      end
      default: ;
    endcase
    if (!legal) begin
      alu_op  = ALU_NOP;
      alu_sel = SEL_NOP;
    end
  end

  function automatic word_t pick_operand(logic re, reg_addr_t addr, word_t rf_data,
                                         word_t imm_val, fwd_t exf, fwd_t wbf);
    word_t opnd;
    if (!re) begin
      opnd = imm_val;
    end else if (addr == `MIPS_REG_ZERO) begin
      opnd = '0;
    end else if (exf.wreg && (exf.wd == addr)) begin
      opnd = exf.wdata;
    end else if (wbf.wreg && (wbf.wd == addr)) begin
      opnd = wbf.wdata;
    end else begin
      opnd = rf_data;
    end
    return opnd;
  endfunction

  always_comb begin
    ex_req_d.valid   = inst_valid_i;
    ex_req_d.illegal = inst_valid_i & ~legal;
    ex_req_d.alu_op  = alu_op;
    ex_req_d.alu_sel = alu_sel;
    ex_req_d.wreg    = inst_valid_i & legal;
    ex_req_d.wd      = wd;
    ex_req_d.opnd1   = pick_operand(rs_re, rs, rs_data_i, imm_fnl, ex_fwd_i, wb_fwd_i);
    ex_req_d.opnd2   = pick_operand(rt_re, rt, rt_data_i, imm_fnl, ex_fwd_i, wb_fwd_i);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_req_o <= '0;
    end else begin
      ex_req_o <= ex_req_d;
    end
  end

  // an illegal instruction must never reach write-back with a write
  a_illegal_no_wreg: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(ex_req_o.illegal && ex_req_o.wreg));

endmodule

// File: hw/alu_exec.sv
`timescale 1ns/10ps

module alu_exec
  import mips_pkg::*;
(
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  ex_req_t ex_req_i,
  output fwd_t    ex_fwd_o,
  output wb_req_t wb_req_o
);

  word_t      opnd1;
  word_t      opnd2;
  logic [4:0] sa;
  word_t      logic_res;
  word_t      shift_res;
  word_t      arith_res;
  word_t      result;

  assign opnd1 = ex_req_i.opnd1;
  assign opnd2 = ex_req_i.opnd2;
  assign sa    = opnd1[4:0];

  always_comb begin
    logic_res = '0;
    shift_res = '0;
    arith_res = '0;
    case (ex_req_i.alu_op)
      ALU_OR:   logic_res = opnd1 | opnd2;
      ALU_AND:  logic_res = opnd1 & opnd2;
      ALU_XOR:  logic_res = opnd1 ^ opnd2;
      ALU_NOR:  logic_res = ~(opnd1 | opnd2);
      ALU_SLL:  shift_res = opnd2 << sa;
      ALU_SRL:  shift_res = opnd2 >> sa;
      ALU_SRA:  shift_res = word_t'($signed(opnd2) >>> sa);
      ALU_ADDU: arith_res = opnd1 + opnd2;
      ALU_SUBU: arith_res = opnd1 - opnd2;
      ALU_SLT:  arith_res = {31'h0, $signed(opnd1) < $signed(opnd2)};
      ALU_SLTU: arith_res = {31'h0, opnd1 < opnd2};
      default: ;
    endcase
  end

  always_comb begin
    case (ex_req_i.alu_sel)
      SEL_LOGIC: result = logic_res;
      SEL_SHIFT: result = shift_res;
      SEL_ARITH: result = arith_res;
      default:   result = '0;
    endcase
  end

  // bypass for the instruction right behind
  assign ex_fwd_o.wreg  = ex_req_i.valid & ex_req_i.wreg;
  assign ex_fwd_o.wd    = ex_req_i.wd;
  assign ex_fwd_o.wdata = result;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_req_o <= '0;
    end else begin
      wb_req_o.valid   <= ex_req_i.valid;
      wb_req_o.illegal <= ex_req_i.illegal;
      wb_req_o.wreg    <= ex_req_i.wreg;
      wb_req_o.wd      <= ex_req_i.wd;
      wb_req_o.wdata   <= result;
    end
  end

  // decode must tag every legal instruction with a result group
  a_legal_has_sel: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ex_req_i.valid && !ex_req_i.illegal) |-> (ex_req_i.alu_sel != SEL_NOP));

endmodule

// File: hw/result_stage.sv
`timescale 1ns/10ps
`include "mips_macros.svh"

module result_stage
  import mips_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  wb_req_t   wb_req_i,
  output fwd_t      wb_fwd_o,
  output logic      we_o,
  output reg_addr_t waddr_o,
  output word_t     wdata_o,
  output logic      wb_valid_o,
  output reg_addr_t wb_addr_o,
  output word_t     wb_data_o,
  output logic      illegal_o
);

  logic wr_en;

  // writes to r0 are dropped here
  assign wr_en = wb_req_i.valid & ~wb_req_i.illegal & wb_req_i.wreg &
                 (wb_req_i.wd != `MIPS_REG_ZERO);

  assign we_o    = wr_en;
  assign waddr_o = wb_req_i.wd;
  assign wdata_o = wb_req_i.wdata;

  assign wb_fwd_o.wreg  = wr_en;
  assign wb_fwd_o.wd    = wb_req_i.wd;
  assign wb_fwd_o.wdata = wb_req_i.wdata;

  assign wb_valid_o = wr_en;
  assign wb_addr_o  = wb_req_i.wd;
  assign wb_data_o  = wb_req_i.wdata;
  assign illegal_o  = wb_req_i.valid & wb_req_i.illegal;

  a_wb_addr_nonzero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_valid_o |-> (wb_addr_o != `MIPS_REG_ZERO));

endmodule

// File: hw/mips_core.sv
`timescale 1ns/10ps

module mips_core
  import mips_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      inst_valid_i,
  input  word_t     inst_i,
  output logic      wb_valid_o,
  output reg_addr_t wb_addr_o,
  output word_t     wb_data_o,
  output logic      illegal_o
);

  reg_addr_t rs_addr;
  reg_addr_t rt_addr;
  word_t     rs_data;
  word_t     rt_data;
  ex_req_t   ex_req;
  wb_req_t   wb_req;
  fwd_t      ex_fwd;
  fwd_t      wb_fwd;
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  inst_decoder u_inst_decoder (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .rs_addr_o    (rs_addr),
    .rt_addr_o    (rt_addr),
    .rs_data_i    (rs_data),
    .rt_data_i    (rt_data),
    .ex_fwd_i     (ex_fwd),
    .wb_fwd_i     (wb_fwd),
    .ex_req_o     (ex_req)
  );

  reg_file u_reg_file (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .rs_addr_i (rs_addr),
    .rt_addr_i (rt_addr),
    .rs_data_o (rs_data),
    .rt_data_o (rt_data),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  alu_exec u_alu_exec (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .ex_req_i (ex_req),
    .ex_fwd_o (ex_fwd),
    .wb_req_o (wb_req)
  );

  result_stage u_result_stage (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .wb_req_i   (wb_req),
    .wb_fwd_o   (wb_fwd),
    .we_o       (rf_we),
    .waddr_o    (rf_waddr),
    .wdata_o    (rf_wdata),
    .wb_valid_o (wb_valid_o),
    .wb_addr_o  (wb_addr_o),
    .wb_data_o  (wb_data_o),
    .illegal_o  (illegal_o)
  );

endmodule

// File: tests/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// expected response of one instruction
typedef struct packed {
  logic      wb;
  logic      illegal;
  reg_addr_t addr;
  word_t     data;
} expect_t;

// architectural view, updated in program order
word_t shadow [`MIPS_NREGS];

function automatic word_t r_format(input reg_addr_t rs, input reg_addr_t rt,
                                   input reg_addr_t rd, input logic [4:0] sh,
                                   input logic [5:0] fn);
  return {`OP_SPECIAL, rs, rt, rd, sh, fn};
endfunction

function automatic word_t i_format(input logic [5:0] op, input reg_addr_t rs,
                                   input reg_addr_t rt, input logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

function automatic expect_t predict_result(input word_t inst);
  expect_t    e;
  logic [5:0] op;
  logic [5:0] fn;
  logic [4:0] sh;
  logic       ok;
  word_t      a;
  word_t      b;
  word_t      zi;
  word_t      si;
  word_t      r;
  op = inst[31:26];
  fn = inst[5:0];
  sh = inst[10:6];
  a  = shadow[inst[25:21]];
  b  = shadow[inst[20:16]];
  zi = {16'h0, inst[15:0]};
  si = {{16{inst[15]}}, inst[15:0]};
  r  = '0;
  ok = 1'b1;
  e  = '0;
  e.addr = inst[20:16];
  if (op == `OP_SPECIAL) begin
    e.addr = inst[15:11];
    // fixed shifts need rs clear, all others need shamt clear
    if (fn == `FN_SLL || fn == `FN_SRL || fn == `FN_SRA) begin
      ok = (inst[25:21] == 5'd0);
    end else begin
      ok = (sh == 5'd0);
    end
    case (fn)
      `FN_OR:   r = a | b;
      `FN_AND:  r = a & b;
      `FN_XOR:  r = a ^ b;
      `FN_NOR:  r = ~(a | b);
      `FN_SLL:  r = b << sh;
      `FN_SRL:  r = b >> sh;
      `FN_SRA:  r = word_t'($signed(b) >>> sh);
      `FN_SLLV: r = b << a[4:0];
      `FN_SRLV: r = b >> a[4:0];
      `FN_SRAV: r = word_t'($signed(b) >>> a[4:0]);
      `FN_ADDU: r = a + b;
      `FN_SUBU: r = a - b;
      `FN_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      `FN_SLTU: r = (a < b) ? 32'd1 : 32'd0;
      default:  ok = 1'b0;
    endcase
  end else begin
    case (op)
      `OP_ORI:   r = a | zi;
      `OP_ANDI:  r = a & zi;
      `OP_XORI:  r = a ^ zi;
      `OP_LUI:   r = {inst[15:0], 16'h0};
      `OP_ADDIU: r = a + si;
      `OP_SLTI:  r = ($signed(a) < $signed(si)) ? 32'd1 : 32'd0;
      `OP_SLTIU: r = (a < si) ? 32'd1 : 32'd0;
      default:   ok = 1'b0;
    endcase
  end
  e.illegal = ~ok;
  e.wb      = ok && (e.addr != 5'd0);
  e.data    = r;
  if (e.wb) begin
    shadow[e.addr] = r;
  end
  return e;
endfunction

`endif

// File: tests/tb_mips_core.sv
`timescale 1ns/10ps
`include "mips_macros.svh"

module tb_mips_core
  import mips_pkg::*;
();

  logic      clk;
  logic      arst_n;
  logic      inst_valid;
  word_t     inst;
  logic      wb_valid;
  reg_addr_t wb_addr;
  word_t     wb_data;
  logic      illegal;
  integer    seed;
  word_t     burst_q [$];

  localparam int pulse_wait = 8;
  localparam logic [5:0] imm_ops [7] = '{`OP_ORI, `OP_ANDI, `OP_XORI, `OP_LUI,
                                         `OP_ADDIU, `OP_SLTI, `OP_SLTIU};
  // last three are the fixed shifts
  localparam logic [5:0] reg_fns [14] = '{`FN_OR, `FN_AND, `FN_XOR, `FN_NOR, `FN_ADDU,
                                          `FN_SUBU, `FN_SLT, `FN_SLTU, `FN_SLLV, `FN_SRLV,
                                          `FN_SRAV, `FN_SLL, `FN_SRL, `FN_SRA};

  `include "tb_ref_model.svh"

  mips_core DUT (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .inst_valid_i (inst_valid),
    .inst_i       (inst),
    .wb_valid_o   (wb_valid),
    .wb_addr_o    (wb_addr),
    .wb_data_o    (wb_data),
    .illegal_o    (illegal)
  );

  always #2 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_wb(input logic exp_valid, input reg_addr_t exp_addr,
                          input word_t exp_data);
    if (wb_valid !== exp_valid) begin
      stop_run($sformatf("Mismatch wb_valid_o: got %h, expected %h", wb_valid, exp_valid));
    end
    if (exp_valid && (wb_addr !== exp_addr)) begin
      stop_run($sformatf("Mismatch wb_addr_o: got %h, expected %h", wb_addr, exp_addr));
    end
    if (exp_valid && (wb_data !== exp_data)) begin
      stop_run($sformatf("Mismatch wb_data_o: got %h, expected %h", wb_data, exp_data));
    end
  endtask

  task automatic check_illegal(input bit exp_illegal);
    if (illegal !== exp_illegal) begin
      stop_run($sformatf("Mismatch illegal_o: got %h, expected %h", illegal, exp_illegal));
    end
  endtask

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  function automatic reg_addr_t rand_reg();
    word_t v;
    v = $random(seed);
    return (v[4:0] == 5'd0) ? 5'd1 : v[4:0];
  endfunction

  // one instruction followed by bubbles
  task automatic run_single(input word_t word);
    expect_t e;
    int      n;
    e = predict_result(word);
    @(posedge clk);
    inst_valid <= 1'b1;
    inst       <= word;
    @(posedge clk);
    inst_valid <= 1'b0;
    inst       <= '0;
    // count falling edges after the sampling edge
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!(wb_valid || illegal) && (n < pulse_wait));
    if ((e.wb || e.illegal) && !(wb_valid || illegal)) begin
      stop_run("no write-back or illegal pulse before the timeout");
    end
    if ((e.wb || e.illegal) && (n != 2)) begin
      stop_run($sformatf("pulse came %0d cycles after sampling instead of 2", n));
    end
    check_wb(e.wb, e.addr, e.data);
    check_illegal(e.illegal);
    if (e.wb || e.illegal) begin
      @(negedge clk);
      if (wb_valid || illegal) begin
        stop_run("pulse stayed high for more than one cycle");
      end
    end
  endtask

  // back to back issue, fixed two-edge latency
  task automatic run_burst();
    expect_t exp_q [$];
    int      n;
    int      i;
    n = burst_q.size();
    for (i = 0; i < n; i++) begin
      exp_q.push_back(predict_result(burst_q[i]));
    end
    for (i = 0; i < n + 2; i++) begin
      @(posedge clk);
      if (i < n) begin
        inst_valid <= 1'b1;
        inst       <= burst_q[i];
      end else begin
        inst_valid <= 1'b0;
        inst       <= '0;
      end
      @(negedge clk);
      if (i >= 2) begin
        check_wb(exp_q[i-2].wb, exp_q[i-2].addr, exp_q[i-2].data);
        check_illegal(exp_q[i-2].illegal);
      end else begin
        check_wb(1'b0, '0, '0);
        check_illegal(1'b0);
      end
    end
    burst_q.delete();
  endtask

  task automatic load_reg(input reg_addr_t r, input word_t v);
    run_single(i_format(`OP_LUI, 5'd0, r, v[31:16]));
    run_single(i_format(`OP_ORI, r, r, v[15:0]));
  endtask

  task automatic idle_outputs();
    int i;
    for (i = 0; i < 10; i++) begin
      @(negedge clk);
      check_wb(1'b0, '0, '0);
      check_illegal(1'b0);
    end
  endtask

  task automatic imm_forms();
    reg_addr_t rs;
    word_t     v;
    int        i;
    repeat (3) begin
      for (i = 0; i < 7; i++) begin
        rs = rand_reg();
        load_reg(rs, rand_word());
        v = rand_word();
        run_single(i_format(imm_ops[i], rs, rand_reg(), v[15:0]));
      end
    end
  endtask

  task automatic reg_forms();
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     v;
    int        i;
    repeat (3) begin
      for (i = 0; i < 14; i++) begin
        rs = rand_reg();
        rt = rand_reg();
        load_reg(rs, rand_word());
        load_reg(rt, rand_word());
        v = rand_word();
        if (i >= 11) begin
          run_single(r_format(5'd0, rt, rand_reg(), v[4:0], reg_fns[i]));
        end else begin
          run_single(r_format(rs, rt, rand_reg(), 5'd0, reg_fns[i]));
        end
      end
    end
  endtask

  // reads at distance 1, 2 and 3 from their producers
  task automatic forwarding_chain();
    word_t v;
    repeat (4) begin
      v = rand_word();
      burst_q.push_back(i_format(`OP_LUI, 5'd0, 5'd5, v[31:16]));
      burst_q.push_back(i_format(`OP_ORI, 5'd5, 5'd5, v[15:0]));
      v = rand_word();
      burst_q.push_back(i_format(`OP_ADDIU, 5'd5, 5'd6, v[15:0]));
      burst_q.push_back(r_format(5'd6, 5'd5, 5'd7, 5'd0, `FN_ADDU));
      burst_q.push_back(r_format(5'd7, 5'd5, 5'd8, 5'd0, `FN_SUBU));
      burst_q.push_back(r_format(5'd6, 5'd8, 5'd9, 5'd0, `FN_XOR));
      burst_q.push_back(r_format(5'd7, 5'd9, 5'd10, 5'd0, `FN_SLLV));
      burst_q.push_back(r_format(5'd10, 5'd8, 5'd11, 5'd0, `FN_SLT));
      burst_q.push_back(r_format(5'd11, 5'd10, 5'd5, 5'd0, `FN_NOR));
      run_burst();
    end
  endtask

  task automatic reg_zero_writes();
    reg_addr_t rs;
    word_t     v;
    rs = rand_reg();
    v  = rand_word();
    load_reg(rs, v);
    run_single(i_format(`OP_ADDIU, rs, 5'd0, v[15:0]));
    run_single(r_format(5'd0, rs, rand_reg(), 5'd0, `FN_ADDU));
    // r0 right behind a write to r0
    burst_q.push_back(i_format(`OP_ORI, rs, 5'd0, 16'hffff));
    burst_q.push_back(r_format(5'd0, 5'd0, 5'd12, 5'd0, `FN_NOR));
    burst_q.push_back(r_format(rs, 5'd0, 5'd13, 5'd0, `FN_OR));
    burst_q.push_back(r_format(5'd0, rs, 5'd14, 5'd0, `FN_SUBU));
    run_burst();
  endtask

  task automatic illegal_inst();
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     v;
    rt = rand_reg();
    v  = rand_word();
    load_reg(rt, v);
    // lw opcode is outside the kept set
    run_single(i_format(6'b100011, rand_reg(), rt, v[15:0]));
    run_single(r_format(rt, 5'd0, rand_reg(), 5'd0, `FN_OR));
    rd = rand_reg();
    load_reg(rd, rand_word());
    run_single(r_format(rt, rt, rd, 5'd0, 6'b011000));
    run_single(r_format(rd, 5'd0, rand_reg(), 5'd0, `FN_OR));
    burst_q.push_back(i_format(`OP_ADDIU, 5'd0, 5'd15, 16'h1234));
    burst_q.push_back(r_format(5'd15, 5'd15, 5'd15, 5'd0, 6'b011000));
    burst_q.push_back(r_format(5'd15, 5'd0, 5'd16, 5'd0, `FN_OR));
    run_burst();
  endtask

  initial begin
    int i;
    seed       = 70579;
    clk        = 1'b0;
    arst_n     = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    for (i = 0; i < `MIPS_NREGS; i++) begin
      shadow[i] = '0;
    end
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    idle_outputs();
    imm_forms();
    reg_forms();
    forwarding_chain();
    reg_zero_writes();
    illegal_inst();
    idle_outputs();
    $display("Regression passed");
    $finish;
  end

endmodule

// File: flist.f
+incdir+common
+incdir+tests
common/mips_pkg.sv
decode/reg_file.sv
decode/inst_decoder.sv
hw/alu_exec.sv
hw/result_stage.sv
hw/mips_core.sv
tests/tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run tb_mips_core with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_mips_core \
  -f flist.f \
  -o tb_mips_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mips_core > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Regression passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
